// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

  localparam int unsigned WORD_W = 32;          // Data word bits
  localparam int unsigned BE_W   = WORD_W / 8;  // One enable per byte
  localparam int unsigned ADDR_W = 32;          // Byte address bits

  typedef logic [WORD_W-1:0] word_t;  // One data word
  typedef logic [BE_W-1:0]   be_t;    // Byte-lane write enables
  typedef logic [ADDR_W-1:0] addr_t;  // Byte address, low 2 bits unused

  // Lookup strobe into both ways
  typedef struct packed {
    logic  valid;  // Single-cycle lookup pulse
    addr_t addr;   // Address to look up
  } lkup_req_t;

  // Write into one chosen way
  typedef struct packed {
    logic  valid;  // Single-cycle write pulse
    logic  way;    // Target way
    addr_t addr;   // Sets index and new tag
    be_t   be;     // Data byte lanes to write
    word_t data;   // Write data
  } wr_req_t;

  // Result of one way for the pending lookup
  typedef struct packed {
    logic  hit;   // Valid entry with matching tag
    word_t data;  // Word read from this way
  } way_res_t;

endpackage

`default_nettype wire

// File: wired_dpsram.sv
`timescale 1ns/1ps
`default_nettype none

module wired_dpsram #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned DATA_DEPTH = 256,
  parameter int unsigned BYTE_SIZE  = 8
) (
  input  wire                                 clk0,
  input  wire                                 reset_i,
  // Port A, lookup reads
  input  wire  [$clog2(DATA_DEPTH)-1:0]       addr0_i,
  input  wire                                 en0_i,
  output logic [DATA_WIDTH-1:0]               rdata0_o,
  // Port B, byte-lane writes
  input  wire  [$clog2(DATA_DEPTH)-1:0]       addr1_i,
  input  wire                                 en1_i,
  input  wire  [(DATA_WIDTH/BYTE_SIZE)-1:0]   we1_i,
  input  wire  [DATA_WIDTH-1:0]               wdata1_i,
  output logic [DATA_WIDTH-1:0]               rdata1_o
);

  localparam int unsigned LANES = DATA_WIDTH / BYTE_SIZE;  // Write lanes per word

  typedef logic [LANES-1:0][BYTE_SIZE-1:0] lanes_t;  // Word split into lanes

  lanes_t mem [DATA_DEPTH];  // Storage array
  lanes_t wdata1_lanes;      // Port B write data by lane
  lanes_t rdata0_q;          // Port A read register
  lanes_t rdata1_q;          // Port B read register

  // Lanes must tile the word exactly
  if (DATA_WIDTH % BYTE_SIZE != 0) begin : g_bad_lanes
    $error("wired_dpsram BYTE_SIZE must divide DATA_WIDTH");
  end

  assign wdata1_lanes = wdata1_i;
  assign rdata0_o     = rdata0_q;
  assign rdata1_o     = rdata1_q;

  // Port A read, sees the word from before a same-edge write
  always_ff @(posedge clk0) begin
    if (reset_i) begin
      rdata0_q <= '0;
    end else if (en0_i) begin
      rdata0_q <= mem[addr0_i];  // Registered read
    end
  end

  // Port B array update
  always_ff @(posedge clk0) begin
    if (en1_i) begin
      for (int i = 0; i < LANES; i++) begin
        if (we1_i[i]) begin
          mem[addr1_i][i] <= wdata1_lanes[i];  // Enabled lanes only
        end
      end
    end
  end

  // Port B readback
  always_ff @(posedge clk0) begin
    if (reset_i) begin
      rdata1_q <= '0;
    end else if (en1_i) begin
      for (int i = 0; i < LANES; i++) begin
        // Write-first per lane
        rdata1_q[i] <= we1_i[i] ? wdata1_lanes[i] : mem[addr1_i][i];
      end
    end
  end

  // Lookup address never X while reading
  a_addr0_known: assert property (
    @(posedge clk0) disable iff (reset_i) en0_i |-> !$isunknown(addr0_i)
  ) else $error("wired_dpsram port A address unknown while enabled");

endmodule

`default_nettype wire

// File: cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way #(
  parameter int unsigned SETS   = 256,
  parameter bit          WAY_ID = 1'b0
) (
  input  wire                       clk0,
  input  wire                       reset_i,
  input  wire cache_pkg::lkup_req_t lkup_i,
  input  wire cache_pkg::wr_req_t   wr_i,
  input  wire                       flush_i,
  output cache_pkg::way_res_t       res_o,
  output logic                      res_valid_o
);

  import cache_pkg::*;

  localparam int unsigned IDX_W = $clog2(SETS);         // Set index bits
  localparam int unsigned TAG_W = ADDR_W - IDX_W - 2;   // Tag above index

  typedef logic [IDX_W-1:0] idx_t;  // Set index
  typedef logic [TAG_W-1:0] tag_t;  // Stored tag

  idx_t            lkup_idx;    // Index of incoming lookup
  tag_t            lkup_tag;    // Tag of incoming lookup
  idx_t            wr_idx;      // Index of incoming write
  tag_t            wr_tag;      // Tag of incoming write
  logic            wr_sel;      // Write targets this way
  logic [SETS-1:0] valid_q;     // One valid bit per set
  logic            vld_q;       // Valid bit of pending lookup
  tag_t            tag_q;       // Tag of pending lookup
  tag_t            tag_rdata;   // Stored tag of pending set
  word_t           data_rdata;  // Stored word of pending set

  assign lkup_idx = lkup_i.addr[IDX_W+1:2];
  assign lkup_tag = lkup_i.addr[ADDR_W-1:IDX_W+2];
  assign wr_idx   = wr_i.addr[IDX_W+1:2];
  assign wr_tag   = wr_i.addr[ADDR_W-1:IDX_W+2];
  assign wr_sel   = wr_i.valid && (wr_i.way == WAY_ID);  // Only our way

  // Tag store, single lane covering the whole tag
  wired_dpsram #(
    .DATA_WIDTH (TAG_W),
    .DATA_DEPTH (SETS),
    .BYTE_SIZE  (TAG_W)
  ) i_tag_ram (
    .clk0     (clk0),
    .reset_i  (reset_i),
    .addr0_i  (lkup_idx),
    .en0_i    (lkup_i.valid),
    .rdata0_o (tag_rdata),
    .addr1_i  (wr_idx),
    .en1_i    (wr_sel),
    .we1_i    (1'b1),        // Tag always fully rewritten
    .wdata1_i (wr_tag),
    .rdata1_o ()             // Write readback not needed
  );

  // Data store, byte lanes
  wired_dpsram #(
    .DATA_WIDTH (WORD_W),
    .DATA_DEPTH (SETS),
    .BYTE_SIZE  (8)
  ) i_data_ram (
    .clk0     (clk0),
    .reset_i  (reset_i),
    .addr0_i  (lkup_idx),
    .en0_i    (lkup_i.valid),
    .rdata0_o (data_rdata),
    .addr1_i  (wr_idx),
    .en1_i    (wr_sel),
    .we1_i    (wr_i.be),     // Partial writes merge in the RAM
    .wdata1_i (wr_i.data),
    .rdata1_o ()
  );

  // Valid bits; flush beats a same-cycle write
  always_ff @(posedge clk0) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;               // Clear every set
    end else if (wr_sel) begin
      valid_q[wr_idx] <= 1'b1;     // Entry now holds a line
    end
  end

  // Pending lookup control, aligned with the RAM read
  always_ff @(posedge clk0) begin
    if (reset_i) begin
      res_valid_o <= 1'b0;
      vld_q       <= 1'b0;
    end else begin
      res_valid_o <= lkup_i.valid;
      vld_q       <= lkup_i.valid && valid_q[lkup_idx];  // Pre-write, pre-flush state
    end
  end

  // Lookup tag held for the compare
  always_ff @(posedge clk0) begin
    if (lkup_i.valid) begin
      tag_q <= lkup_tag;
    end
  end

  assign res_o.hit  = vld_q && (tag_rdata == tag_q);  // Tag compare
  assign res_o.data = data_rdata;

  // Response strobe always defined once out of reset
  a_res_valid_known: assert property (
    @(posedge clk0) disable iff (reset_i) !$isunknown(res_valid_o)
  ) else $error("cache_way %0d response valid unknown", WAY_ID);

endmodule

`default_nettype wire

// File: way_select.sv
`timescale 1ns/1ps
`default_nettype none

module way_select #(
  parameter int unsigned SETS = 256
) (
  input  wire                       clk0,
  input  wire                       reset_i,
  input  wire cache_pkg::lkup_req_t lkup_i,
  input  wire cache_pkg::wr_req_t   wr_i,
  input  wire cache_pkg::way_res_t  res0_i,
  input  wire cache_pkg::way_res_t  res1_i,
  input  wire                       res_valid_i,
  output logic                      hit_o,
  output cache_pkg::word_t          rdata_o,
  output logic                      victim_o,
  output logic                      rsp_valid_o
);

  import cache_pkg::*;

  localparam int unsigned IDX_W = $clog2(SETS);  // Set index bits

  typedef logic [IDX_W-1:0] idx_t;  // Set index

  idx_t            lkup_idx;  // Index of incoming lookup
  idx_t            wr_idx;    // Index of incoming write
  idx_t            idx_q;     // Index of pending lookup
  logic [SETS-1:0] lru_q;     // Next way to replace, per set
  logic            victim_q;  // LRU bit sampled at lookup
  logic            hit_way;   // Way that hit, when hit_o

  assign lkup_idx = lkup_i.addr[IDX_W+1:2];
  assign wr_idx   = wr_i.addr[IDX_W+1:2];

  // Combine way results
  assign hit_o   = res0_i.hit || res1_i.hit;
  assign hit_way = res1_i.hit;  // Way 0 otherwise
  assign rsp_valid_o = res_valid_i;  // No added latency

  always_comb begin
    if (res0_i.hit) begin
      rdata_o = res0_i.data;
    end else if (res1_i.hit) begin
      rdata_o = res1_i.data;
    end else begin
      rdata_o = '0;  // Zero on miss
    end
  end

  // Victim and index for the lookup in flight
  always_ff @(posedge clk0) begin
    if (reset_i) begin
      victim_q <= 1'b0;
    end else if (lkup_i.valid) begin
      victim_q <= lru_q[lkup_idx];  // Value before this edge's updates
    end
  end

  always_ff @(posedge clk0) begin
    if (lkup_i.valid) begin
      idx_q <= lkup_idx;
    end
  end

  assign victim_o = victim_q;

  // LRU update, write assigned last so it wins on the same set
  always_ff @(posedge clk0) begin
    if (reset_i) begin
      lru_q <= '0;  // Victim starts at way 0
    end else begin
      if (hit_o) begin
        lru_q[idx_q] <= ~hit_way;  // Other way becomes LRU
      end
      if (wr_i.valid) begin
        lru_q[wr_idx] <= ~wr_i.way;
      end
    end
  end

  // A tag must live in one way only
  a_one_way_hit: assert property (
    @(posedge clk0) disable iff (reset_i) res_valid_i |-> !(res0_i.hit && res1_i.hit)
  ) else $error("way_select both ways hit the same lookup");

endmodule

`default_nettype wire

// File: cache_lookup_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_lookup_top #(
  parameter int unsigned SETS = 256
) (
  input  wire                       clk0,
  input  wire                       reset_i,
  input  wire cache_pkg::lkup_req_t lkup_i,
  input  wire cache_pkg::wr_req_t   wr_i,
  input  wire                       flush_i,
  output logic                      hit_o,
  output cache_pkg::word_t          rdata_o,
  output logic                      victim_o,
  output logic                      rsp_valid_o
);

  import cache_pkg::*;

  way_res_t res0;       // Way 0 result
  way_res_t res1;       // Way 1 result
  logic     res_valid;  // Shared response strobe

  cache_way #(
    .SETS   (SETS),
    .WAY_ID (1'b0)
  ) i_way0 (
    .clk0        (clk0),
    .reset_i     (reset_i),
    .lkup_i      (lkup_i),
    .wr_i        (wr_i),
    .flush_i     (flush_i),
    .res_o       (res0),
    .res_valid_o (res_valid)
  );

  cache_way #(
    .SETS   (SETS),
    .WAY_ID (1'b1)
  ) i_way1 (
    .clk0        (clk0),
    .reset_i     (reset_i),
    .lkup_i      (lkup_i),
    .wr_i        (wr_i),
    .flush_i     (flush_i),
    .res_o       (res1),
    .res_valid_o ()            // Same as way 0
  );

  way_select #(
    .SETS (SETS)
  ) i_way_select (
    .clk0        (clk0),
    .reset_i     (reset_i),
    .lkup_i      (lkup_i),
    .wr_i        (wr_i),
    .res0_i      (res0),
    .res1_i      (res1),
    .res_valid_i (res_valid),
    .hit_o       (hit_o),
    .rdata_o     (rdata_o),
    .victim_o    (victim_o),
    .rsp_valid_o (rsp_valid_o)
  );

endmodule

`default_nettype wire

// File: tb_cache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_lookup;

  import cache_pkg::*;

  localparam int unsigned SETS  = 256;
  localparam int unsigned IDX_W = $clog2(SETS);  // Index width, same rule as the RTL

  typedef logic [IDX_W-1:0] idx_t;

  // One operation read from the pattern file
  typedef struct packed {
    logic [7:0]  op;          // L W B F I, upper case
    logic        rnd;         // Random write data or modelled read data
    logic        way;         // Write way, or expected hitting way
    addr_t       addr;
    be_t         be;
    word_t       data;
    logic        exp_hit;
    word_t       exp_data;
    logic        exp_victim;
    logic [15:0] line_no;     // Source line for messages
  } pattern_t;

  // Response expected for one lookup
  typedef struct packed {
    logic        hit;
    word_t       data;
    logic        victim;
    logic [15:0] line_no;
  } expect_t;

  logic      clk0;
  logic      reset_i;
  lkup_req_t lkup_i;
  wr_req_t   wr_i;
  logic      flush_i;
  logic      hit_o;
  word_t     rdata_o;
  logic      victim_o;
  logic      rsp_valid_o;

  pattern_t patterns[$];      // Whole file, in order
  expect_t  exp_q[$];         // Lookups awaiting a response
  word_t    shadow [2][SETS]; // Data model per way and set
  logic     lkup_prev;        // Lookup driven in the previous cycle
  int       prev_line;        // Its pattern line
  int       value_errors = 0;
  int       other_errors = 0;
  int       checks       = 0;
  bit       loaded       = 1'b0;
  int       watchdog_ns  = 0;

  cache_lookup_top #(
    .SETS (SETS)
  ) i_cache_lookup_top (
    .clk0        (clk0),
    .reset_i     (reset_i),
    .lkup_i      (lkup_i),
    .wr_i        (wr_i),
    .flush_i     (flush_i),
    .hit_o       (hit_o),
    .rdata_o     (rdata_o),
    .victim_o    (victim_o),
    .rsp_valid_o (rsp_valid_o)
  );

  initial begin
    clk0 = 1'b0;
    forever #5 clk0 = ~clk0;  // 10 ns period
  end

  // Compare one value, report on mismatch
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input int line_no);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %s: got 0x%0h expected 0x%0h (pattern line %0d, t=%0t)",
               name, got, exp, line_no, $time);
    end
  endtask

  // Byte-lane merge of a write into a stored word
  function automatic word_t merge_lanes(word_t old_w, word_t new_w, be_t be);
    word_t res;
    res = old_w;
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];  // Enabled lane takes new byte
      end
    end
    return res;
  endfunction

  task automatic load_patterns(output bit ok);
    int          fd;
    int          cnt;
    int          line_no;
    int          way_v;
    int          hit_v;
    int          vic_v;
    string       line;
    logic [7:0]  op_c;
    logic [31:0] addr_v;
    logic [31:0] be_v;
    logic [31:0] data_v;
    logic [31:0] edata_v;
    pattern_t    p;
    ok      = 1'b0;
    line_no = 0;
    fd      = $fopen("cache_lookup_patterns.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open cache_lookup_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        cnt  = $fgets(line, fd);
        line_no++;
        cnt  = $sscanf(line, " %c", op_c);
        if (cnt == 1 && op_c != "#") begin  // Skip blanks and comments
          cnt = $sscanf(line, " %c %h %h %h %h %h %h %h", op_c, way_v, addr_v,
                        be_v, data_v, hit_v, edata_v, vic_v);
          p.rnd = (op_c >= "a") && (op_c <= "z");  // Lower case marks random
          p.op  = p.rnd ? op_c - 8'd32 : op_c;
          if (cnt != 8) begin
            other_errors++;
            $display("Pattern line %0d does not have eight fields", line_no);
          end else if (p.op != "L" && p.op != "W" && p.op != "B" &&
                       p.op != "F" && p.op != "I") begin
            other_errors++;
            $display("Pattern line %0d has an unknown operation", line_no);
          end else begin
            p.way        = way_v[0];
            p.addr       = addr_v;
            p.be         = be_v[BE_W-1:0];
            p.data       = data_v;
            p.exp_hit    = hit_v[0];
            p.exp_data   = edata_v;
            p.exp_victim = vic_v[0];
            p.line_no    = line_no[15:0];
            patterns.push_back(p);
          end
        end
      end
      $fclose(fd);
      if (patterns.size() == 0) begin
        other_errors++;
        $display("Pattern file holds no operations");
      end
      ok = (patterns.size() > 0) && (other_errors == 0);
    end
  endtask

  // Apply one operation and queue what its lookup must return
  task automatic drive_line(input pattern_t p);
    expect_t e;
    idx_t    idx;
    word_t   wdata;
    idx     = p.addr[IDX_W+1:2];
    wdata   = p.data;
    lkup_i  = '0;
    wr_i    = '0;
    flush_i = 1'b0;
    if (p.rnd && (p.op == "W" || p.op == "B")) begin
      wdata = $urandom();  // Random write data
    end
    if (p.op == "L" || p.op == "B") begin
      lkup_i.valid = 1'b1;
      lkup_i.addr  = p.addr;
      e.hit        = p.exp_hit;
      e.victim     = p.exp_victim;
      e.line_no    = p.line_no;
      if (!p.exp_hit) begin
        e.data = '0;                  // Zero on a miss
      end else if (p.rnd) begin
        e.data = shadow[p.way][idx];  // Model, before this cycle's write
      end else begin
        e.data = p.exp_data;
      end
      exp_q.push_back(e);
    end
    if (p.op == "W" || p.op == "B") begin
      wr_i.valid = 1'b1;
      wr_i.way   = p.way;
      wr_i.addr  = p.addr;
      wr_i.be    = p.be;
      wr_i.data  = wdata;
      shadow[p.way][idx] = merge_lanes(shadow[p.way][idx], wdata, p.be);
    end
    if (p.op == "F") begin
      flush_i = 1'b1;
    end
    lkup_prev = lkup_i.valid;
    prev_line = p.line_no;
  endtask

  // Sampled at the falling edge, outputs are settled
  task automatic check_response();
    expect_t e;
    check_value("rsp_valid_o", rsp_valid_o, lkup_prev, prev_line);  // One cycle latency
    if (rsp_valid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("Response at %0t arrived with no lookup pending", $time);
      end else begin
        e = exp_q.pop_front();
        check_value("hit_o", hit_o, e.hit, e.line_no);
        check_value("rdata_o", rdata_o, e.data, e.line_no);
        check_value("victim_o", victim_o, e.victim, e.line_no);
      end
    end
  endtask

  initial begin : watchdog
    wait (loaded);
    #(watchdog_ns);
    $display("Timeout after %0d ns, the run did not complete", watchdog_ns);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main_seq
    pattern_t idle_p;
    bit       ok;
    int       seed_val;
    seed_val  = $urandom(31);  // Seed once
    reset_i   = 1'b1;
    lkup_i    = '0;
    wr_i      = '0;
    flush_i   = 1'b0;
    lkup_prev = 1'b0;
    prev_line = 0;
    idle_p    = '0;
    idle_p.op = "I";
    load_patterns(ok);
    watchdog_ns = patterns.size() * 30 + 200;
    loaded      = 1'b1;
    repeat (3) @(posedge clk0);  // Reset for 3 cycles
    @(negedge clk0);
    reset_i = 1'b0;
    if (ok) begin
      foreach (patterns[k]) begin
        @(negedge clk0);
        check_response();
        drive_line(patterns[k]);
      end
      @(negedge clk0);
      check_response();  // Last lookup's response
      drive_line(idle_p);
      @(negedge clk0);
      check_response();
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d lookup responses never arrived", exp_q.size());
    end
    $display("Checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cache_lookup_patterns.txt
# op way addr be data exp_hit exp_data exp_victim, all hex; op L W B F I
# lower case op: w uses random data, l takes expected data from the model of that way
L 0 00001004 0 00000000 0 00000000 0
L 0 12345678 0 00000000 0 00000000 0
L 0 00000010 0 00000000 0 00000000 0
W 0 00001004 f 11111111 0 00000000 0
L 0 00001004 0 00000000 1 11111111 1
L 0 00002004 0 00000000 0 00000000 1
W 1 00002004 f 22222222 0 00000000 0
L 0 00002004 0 00000000 1 22222222 0
I 0 00000000 0 00000000 0 00000000 0
L 0 00001004 0 00000000 1 11111111 0
I 0 00000000 0 00000000 0 00000000 0
L 0 00001004 0 00000000 1 11111111 1
L 0 00003004 0 00000000 0 00000000 1
W 0 00000010 f a5a5a5a5 0 00000000 0
W 0 00000010 3 0000beef 0 00000000 0
L 0 00000010 0 00000000 1 a5a5beef 1
W 0 00000010 c 12340000 0 00000000 0
L 0 00000010 0 00000000 1 1234beef 1
w 1 00000410 f 00000000 0 00000000 0
w 1 00000410 6 00000000 0 00000000 0
l 1 00000410 0 00000000 1 00000000 0
L 0 00000010 0 00000000 1 1234beef 0
I 0 00000000 0 00000000 0 00000000 0
L 0 00002004 0 00000000 1 22222222 1
I 0 00000000 0 00000000 0 00000000 0
L 0 00001004 0 00000000 1 11111111 0
I 0 00000000 0 00000000 0 00000000 0
L 0 00001004 0 00000000 1 11111111 1
W 1 00002004 f 33333333 0 00000000 0
I 0 00000000 0 00000000 0 00000000 0
L 0 00002004 0 00000000 1 33333333 0
W 0 00001004 f 44444444 0 00000000 0
I 0 00000000 0 00000000 0 00000000 0
L 0 00001004 0 00000000 1 44444444 1
I 0 00000000 0 00000000 0 00000000 0
B 1 00002004 f 55555555 1 33333333 1
L 0 00002004 0 00000000 1 55555555 0
I 0 00000000 0 00000000 0 00000000 0
B 0 00003004 f 66666666 0 00000000 0
L 0 00003004 0 00000000 1 66666666 1
L 0 00001004 0 00000000 0 00000000 1
W 1 12345678 f 77777777 0 00000000 0
L 0 12345678 0 00000000 1 77777777 0
F 0 00000000 0 00000000 0 00000000 0
L 0 00002004 0 00000000 0 00000000 1
L 0 00003004 0 00000000 0 00000000 1
L 0 00000010 0 00000000 0 00000000 1
L 0 00000410 0 00000000 0 00000000 1
L 0 12345678 0 00000000 0 00000000 0
W 0 00004200 f 89abcdef 0 00000000 0
L 0 00004200 0 00000000 1 89abcdef 1
L 0 00002004 0 00000000 0 00000000 1
L 0 00004200 0 00000000 1 89abcdef 1

// File: sim.f
cache_pkg.sv
wired_dpsram.sv
cache_way.sv
way_select.sv
cache_lookup_top.sv
tb_cache_lookup.sv
